// File: src/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Register file and datapath width
`define DATA_WIDTH 32

// Register index width, also the shift amount width
`define REG_IDX_WIDTH 5

// Quotient returned for a zero divisor
`define DIV_ZERO_QUOT {`DATA_WIDTH{1'b1}}

`endif

// File: src/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFields;

	// Same 32 bits, read by format
	typedef union packed {
		rFields rFmt;
		iFields iFmt;
	} instrWord;

	localparam logic [5:0] opcRType = 6'b000000; // All R-type share this
	localparam logic [5:0] opcJ = 6'b000010;
	localparam logic [5:0] opcJal = 6'b000011;
	localparam logic [5:0] opcBeq = 6'b000100;
	localparam logic [5:0] opcBne = 6'b000101;
	localparam logic [5:0] opcAddi = 6'b001000;
	localparam logic [5:0] opcSlti = 6'b001010;
	localparam logic [5:0] opcAndi = 6'b001100;
	localparam logic [5:0] opcOri = 6'b001101;
	localparam logic [5:0] opcLw = 6'b100011;
	localparam logic [5:0] opcSw = 6'b101011;

	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnJr = 6'b001000;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnMul = 6'b011001; // Takes the multu slot
	localparam logic [5:0] fnDiv = 6'b011010;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;

endpackage

`default_nettype wire

// File: src/aluPkg.sv
`default_nettype none

`include "exec_defines.svh"

package aluPkg;

	// Main decoder to ALU control
	typedef enum logic [2:0] {
		opAdd = 3'b000,
		opRType = 3'b001, // Funct field decides
		opLogicAnd = 3'b010,
		opLogicOr = 3'b011,
		opSub = 3'b100,
		opSubNe = 3'b101, // bne gets its own code
		opSetLess = 3'b110,
		opNone = 3'b111
	} aluOpKind;

	typedef enum logic [3:0] {
		selAdd = 4'b0000,
		selSll = 4'b0010,
		selSrl = 4'b0011,
		selSub = 4'b0100,
		selSlt = 4'b0101,
		selSubNe = 4'b0110,
		selMflo = 4'b0111,
		selAnd = 4'b1000,
		selMul = 4'b1001,
		selOr = 4'b1010,
		selDiv = 4'b1011,
		selNor = 4'b1100,
		selMult = 4'b1101,
		selMfhi = 4'b1110,
		selNop = 4'b1111
	} aluSel;

	typedef struct packed {
		aluSel sel;
		logic [`REG_IDX_WIDTH-1:0] destReg;
		logic writeEn;
		logic isBranch;
	} decodedCtrl;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] opA;
		logic [`DATA_WIDTH-1:0] opB;
		logic [`REG_IDX_WIDTH-1:0] shamt;
	} operandSet;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] result;
		logic [`REG_IDX_WIDTH-1:0] destReg;
		logic writeEn;
		logic branchTaken;
		logic vld;
	} execResult;

endpackage

`default_nettype wire

// File: src/aluControl.sv
`timescale 1ns/100ps
`default_nettype none

module aluControl (
	input aluPkg::aluOpKind aluOp,
	input logic [5:0] funct,
	output aluPkg::aluSel sel
);

	always_comb
	begin
		case (aluOp)
			aluPkg::opAdd: sel = aluPkg::selAdd; // addi, lw, sw
			aluPkg::opSub: sel = aluPkg::selSub; // beq
			aluPkg::opSubNe: sel = aluPkg::selSubNe; // bne
			aluPkg::opSetLess: sel = aluPkg::selSlt; // slti
			aluPkg::opLogicAnd: sel = aluPkg::selAnd; // andi
			aluPkg::opLogicOr: sel = aluPkg::selOr; // ori
			aluPkg::opRType:
			begin
				case (funct)
					isaPkg::fnAdd: sel = aluPkg::selAdd;
					isaPkg::fnSub: sel = aluPkg::selSub;
					isaPkg::fnAnd: sel = aluPkg::selAnd;
					isaPkg::fnOr: sel = aluPkg::selOr;
					isaPkg::fnNor: sel = aluPkg::selNor;
					isaPkg::fnSlt: sel = aluPkg::selSlt;
					isaPkg::fnSll: sel = aluPkg::selSll;
					isaPkg::fnSrl: sel = aluPkg::selSrl;
					isaPkg::fnMult: sel = aluPkg::selMult;
					isaPkg::fnMul: sel = aluPkg::selMul;
					isaPkg::fnDiv: sel = aluPkg::selDiv;
					isaPkg::fnMfhi: sel = aluPkg::selMfhi;
					isaPkg::fnMflo: sel = aluPkg::selMflo;
					isaPkg::fnJr: sel = aluPkg::selNop; // Jump handled elsewhere
					default: sel = aluPkg::selNop; // Unknown funct
				endcase
			end
			default: sel = aluPkg::selNop; // j, jal, unknown opcode
		endcase
	end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
	input isaPkg::instrWord instr,
	output aluPkg::decodedCtrl ctrl
);

	aluPkg::aluOpKind aluOp;
	aluPkg::aluSel selW;
	logic isRType;
	logic rWrite;

	assign isRType = (instr.rFmt.opcode == isaPkg::opcRType);

	always_comb
	begin
		case (instr.iFmt.opcode)
			isaPkg::opcRType: aluOp = aluPkg::opRType;
			isaPkg::opcAddi, isaPkg::opcLw, isaPkg::opcSw: aluOp = aluPkg::opAdd;
			isaPkg::opcBeq: aluOp = aluPkg::opSub;
			isaPkg::opcBne: aluOp = aluPkg::opSubNe;
			isaPkg::opcSlti: aluOp = aluPkg::opSetLess;
			isaPkg::opcAndi: aluOp = aluPkg::opLogicAnd;
			isaPkg::opcOri: aluOp = aluPkg::opLogicOr;
			isaPkg::opcJ, isaPkg::opcJal: aluOp = aluPkg::opNone; // No ALU work
			default: aluOp = aluPkg::opNone;
		endcase
	end

	// R-type ops that produce a register result
	always_comb
	begin
		case (instr.rFmt.funct)
			isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnOr,
			isaPkg::fnNor, isaPkg::fnSlt, isaPkg::fnSll, isaPkg::fnSrl,
			isaPkg::fnMul, isaPkg::fnMfhi, isaPkg::fnMflo: rWrite = 1'b1;
			default: rWrite = 1'b0; // mult, div, jr land here
		endcase
	end

	aluControl uAluControl (
		.aluOp(aluOp),
		.funct(instr.rFmt.funct),
		.sel(selW)
	);

	always_comb
	begin
		ctrl.sel = selW;
		ctrl.destReg = isRType ? instr.rFmt.rd : instr.iFmt.rt;
		ctrl.isBranch = (instr.iFmt.opcode == isaPkg::opcBeq) ||
			(instr.iFmt.opcode == isaPkg::opcBne);
		case (instr.iFmt.opcode)
			isaPkg::opcRType: ctrl.writeEn = rWrite;
			isaPkg::opcAddi, isaPkg::opcSlti,
			isaPkg::opcAndi, isaPkg::opcOri: ctrl.writeEn = 1'b1;
			default: ctrl.writeEn = 1'b0; // lw and sw only give the address
		endcase
	end

endmodule

`default_nettype wire

// File: src/operandSelect.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module operandSelect (
	input isaPkg::instrWord instr,
	input logic [`DATA_WIDTH-1:0] rsVal,
	input logic [`DATA_WIDTH-1:0] rtVal,
	output aluPkg::operandSet ops
);

	logic isRType;
	logic isShift;
	logic zeroExt;
	logic [`DATA_WIDTH-1:0] immExt;

	assign isRType = (instr.rFmt.opcode == isaPkg::opcRType);
	assign isShift = isRType &&
		(instr.rFmt.funct == isaPkg::fnSll || instr.rFmt.funct == isaPkg::fnSrl);

	// Logical immediates are unsigned
	assign zeroExt = (instr.iFmt.opcode == isaPkg::opcAndi) ||
		(instr.iFmt.opcode == isaPkg::opcOri);

	always_comb
	begin
		if (zeroExt)
			immExt = {{(`DATA_WIDTH-16){1'b0}}, instr.iFmt.imm};
		else
			immExt = {{(`DATA_WIDTH-16){instr.iFmt.imm[15]}}, instr.iFmt.imm};
	end

	always_comb
	begin
		ops.opA = isShift ? rtVal : rsVal; // Shifts work on rt
		ops.opB = isRType ? rtVal : immExt;
		ops.shamt = instr.rFmt.shamt;
	end

endmodule

`default_nettype wire

// File: src/execAlu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module execAlu (
	input logic clk,
	input logic rstN,
	input logic inVld,
	input aluPkg::decodedCtrl ctrl,
	input aluPkg::operandSet ops,
	output aluPkg::execResult out
);

	localparam int W = `DATA_WIDTH;

	logic signed [2*W-1:0] prod;
	logic signed [W-1:0] quot;
	logic signed [W-1:0] rem;
	logic [W-1:0] diff;
	logic [W-1:0] aluRes;
	logic [W-1:0] hiReg;
	logic [W-1:0] loReg;
	logic [W-1:0] hiNext;
	logic [W-1:0] loNext;
	logic hiLoWrite;
	logic lessThan;
	logic takeBranch;

	assign diff = ops.opA - ops.opB;
	assign lessThan = $signed(ops.opA) < $signed(ops.opB);
	assign prod = {{W{ops.opA[W-1]}}, ops.opA} * {{W{ops.opB[W-1]}}, ops.opB}; // Full signed product

	always_comb
	begin
		if (ops.opB == '0)
		begin
			quot = `DIV_ZERO_QUOT;
			rem = ops.opA; // Remainder keeps the dividend
		end
		else
		begin
			quot = $signed(ops.opA) / $signed(ops.opB);
			rem = $signed(ops.opA) % $signed(ops.opB);
		end
	end

	always_comb
	begin
		case (ctrl.sel)
			aluPkg::selAdd: aluRes = ops.opA + ops.opB;
			aluPkg::selSub, aluPkg::selSubNe: aluRes = diff;
			aluPkg::selAnd: aluRes = ops.opA & ops.opB;
			aluPkg::selOr: aluRes = ops.opA | ops.opB;
			aluPkg::selNor: aluRes = ~(ops.opA | ops.opB);
			aluPkg::selSlt: aluRes = {{(W-1){1'b0}}, lessThan};
			aluPkg::selSll: aluRes = ops.opA << ops.shamt;
			aluPkg::selSrl: aluRes = ops.opA >> ops.shamt; // Logical shift
			aluPkg::selMul: aluRes = prod[W-1:0];
			aluPkg::selMfhi: aluRes = hiReg;
			aluPkg::selMflo: aluRes = loReg;
			default: aluRes = '0; // mult, div and nop return nothing
		endcase
	end

	// HI/LO update for mult and div
	always_comb
	begin
		hiLoWrite = 1'b0;
		hiNext = hiReg;
		loNext = loReg;
		if (ctrl.sel == aluPkg::selMult)
		begin
			hiLoWrite = 1'b1;
			hiNext = prod[2*W-1:W];
			loNext = prod[W-1:0];
		end
		else if (ctrl.sel == aluPkg::selDiv)
		begin
			hiLoWrite = 1'b1;
			hiNext = rem;
			loNext = quot;
		end
	end

	always_comb
	begin
		case (ctrl.sel)
			aluPkg::selSub: takeBranch = ctrl.isBranch && (diff == '0); // beq
			aluPkg::selSubNe: takeBranch = ctrl.isBranch && (diff != '0); // bne
			default: takeBranch = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			out <= '0;
			hiReg <= '0;
			loReg <= '0;
		end
		else
		begin
			out.vld <= inVld;
			out.writeEn <= inVld & ctrl.writeEn;
			out.branchTaken <= inVld & takeBranch;
			if (inVld)
			begin
				out.result <= aluRes;
				out.destReg <= ctrl.destReg;
				if (hiLoWrite)
				begin
					hiReg <= hiNext; // Visible to the next mfhi
					loReg <= loNext;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/execStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module execStage (
	input logic clk,
	input logic rstN,
	input logic inVld,
	input isaPkg::instrWord instr,
	input logic [`DATA_WIDTH-1:0] rsVal,
	input logic [`DATA_WIDTH-1:0] rtVal,
	output aluPkg::execResult out
);

	aluPkg::decodedCtrl ctrl;
	aluPkg::operandSet ops;

	// Control path
	instrDecoder uDecoder (
		.instr(instr),
		.ctrl(ctrl)
	);

	// Data path, in parallel with the decoder
	operandSelect uOperands (
		.instr(instr),
		.rsVal(rsVal),
		.rtVal(rtVal),
		.ops(ops)
	);

	execAlu uAlu (
		.clk(clk),
		.rstN(rstN),
		.inVld(inVld),
		.ctrl(ctrl),
		.ops(ops),
		.out(out)
	);

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam time HALF_PERIOD = 20; // 40 ns period

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released on a falling edge after 4 rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/execStage_props.sv
`timescale 1ns/100ps
`default_nettype none

module execStage_props (
	input logic clk,
	input logic rstN,
	input logic inVld,
	input aluPkg::execResult out
);

	vldLowInReset: assert property (@(posedge clk) !rstN |-> !out.vld)
		else $error("out.vld is high while reset is held");

	// Fixed one-cycle latency
	vldAfterIn: assert property (@(posedge clk) disable iff (!rstN) inVld |=> out.vld)
		else $error("out.vld did not follow inVld by one cycle");

	branchNeedsVld: assert property (@(posedge clk) out.branchTaken |-> out.vld)
		else $error("branchTaken is high without out.vld");

endmodule

`default_nettype wire

// File: tests/execStageTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module execStageTb;

	localparam int W = `DATA_WIDTH;
	localparam int CYCLE_LIMIT = 1500; // Tests need roughly 960 cycles

	logic clk;
	logic rstN;
	logic inVld;
	isaPkg::instrWord instr;
	logic [W-1:0] rsVal;
	logic [W-1:0] rtVal;
	aluPkg::execResult out;

	logic [W-1:0] modelHi;
	logic [W-1:0] modelLo;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int cycles = 0;

	clockGen uClk (
		.clk(clk),
		.rstN(rstN)
	);

	execStage DUT (
		.clk(clk),
		.rstN(rstN),
		.inVld(inVld),
		.instr(instr),
		.rsVal(rsVal),
		.rtVal(rtVal),
		.out(out)
	);

	bind execStage execStage_props uProps (
		.clk(clk),
		.rstN(rstN),
		.inVld(inVld),
		.out(out)
	);

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic isaPkg::instrWord randR(input logic [5:0] fn);
		isaPkg::instrWord w;
		w = $urandom; // Random rs, rt, rd and shamt
		w.rFmt.opcode = isaPkg::opcRType;
		w.rFmt.funct = fn;
		return w;
	endfunction

	function automatic isaPkg::instrWord randI(input logic [5:0] opc);
		isaPkg::instrWord w;
		w = $urandom;
		w.iFmt.opcode = opc;
		return w;
	endfunction

	// Expected output of one accepted instruction, HI/LO model updated in place
	task automatic predict(input isaPkg::instrWord iw, input logic [W-1:0] rs,
		input logic [W-1:0] rt, output aluPkg::execResult e);
		logic signed [2*W-1:0] a64;
		logic signed [2*W-1:0] b64;
		logic signed [2*W-1:0] q64;
		logic signed [2*W-1:0] r64;
		logic [2*W-1:0] p;
		logic [W-1:0] sImm;
		logic [W-1:0] zImm;
		logic [5:0] opc;
		a64 = {{W{rs[W-1]}}, rs};
		b64 = {{W{rt[W-1]}}, rt};
		p = a64 * b64;
		sImm = {{(W-16){iw.iFmt.imm[15]}}, iw.iFmt.imm};
		zImm = {{(W-16){1'b0}}, iw.iFmt.imm};
		opc = iw.iFmt.opcode;
		e = '0;
		e.vld = 1'b1;
		if (opc == 6'd0)
		begin
			e.destReg = iw.rFmt.rd;
			e.writeEn = 1'b1;
			case (iw.rFmt.funct)
				isaPkg::fnAdd: e.result = rs + rt;
				isaPkg::fnSub: e.result = rs - rt;
				isaPkg::fnAnd: e.result = rs & rt;
				isaPkg::fnOr: e.result = rs | rt;
				isaPkg::fnNor: e.result = ~(rs | rt);
				isaPkg::fnSlt: e.result = {{(W-1){1'b0}}, a64 < b64};
				isaPkg::fnSll: e.result = rt << iw.rFmt.shamt;
				isaPkg::fnSrl: e.result = rt >> iw.rFmt.shamt;
				isaPkg::fnMul: e.result = p[W-1:0];
				isaPkg::fnMfhi: e.result = modelHi;
				isaPkg::fnMflo: e.result = modelLo;
				isaPkg::fnMult:
				begin
					e.writeEn = 1'b0;
					modelHi = p[2*W-1:W];
					modelLo = p[W-1:0];
				end
				isaPkg::fnDiv:
				begin
					e.writeEn = 1'b0;
					modelHi = rs; // Zero divisor keeps the dividend
					modelLo = '1;
					if (rt != '0)
					begin
						q64 = a64 / b64;
						r64 = a64 % b64;
						modelHi = r64[W-1:0];
						modelLo = q64[W-1:0];
					end
				end
				default: e.writeEn = 1'b0; // jr and unknown funct
			endcase
		end
		else
		begin
			e.destReg = iw.iFmt.rt;
			case (opc)
				isaPkg::opcAddi, isaPkg::opcLw, isaPkg::opcSw: e.result = rs + sImm;
				isaPkg::opcSlti: e.result = {{(W-1){1'b0}}, $signed(rs) < $signed(sImm)};
				isaPkg::opcAndi: e.result = rs & zImm;
				isaPkg::opcOri: e.result = rs | zImm;
				isaPkg::opcBeq, isaPkg::opcBne: e.result = rs - sImm;
				default: e.result = '0; // j, jal, unknown opcodes
			endcase
			e.writeEn = opc inside {isaPkg::opcAddi, isaPkg::opcSlti,
				isaPkg::opcAndi, isaPkg::opcOri};
			e.branchTaken = (opc == isaPkg::opcBeq && rs == sImm) ||
				(opc == isaPkg::opcBne && rs != sImm);
		end
	endtask

	task automatic checkOut(input aluPkg::execResult e, input string what);
		checks++;
		if (out !== e)
		begin
			errors++;
			testErrors++;
			$display("CHECK FAILED at %0t: %s got %h/%0d/%b%b%b, expected %h/%0d/%b%b%b",
				$time, what, out.result, out.destReg, out.writeEn, out.branchTaken, out.vld,
				e.result, e.destReg, e.writeEn, e.branchTaken, e.vld);
		end
	endtask

	// Drive at the falling edge, check one falling edge later
	task automatic runOp(input logic v, input isaPkg::instrWord iw, input logic [W-1:0] rs,
		input logic [W-1:0] rt, input string what);
		aluPkg::execResult e;
		e = '0;
		inVld = v;
		instr = iw;
		rsVal = rs;
		rtVal = rt;
		if (v)
			predict(iw, rs, rt, e);
		@(posedge clk);
		@(negedge clk);
		if (v)
			checkOut(e, what);
		else
		begin
			checks++;
			if (out.vld || out.writeEn || out.branchTaken)
			begin
				errors++;
				testErrors++;
				$display("CHECK FAILED at %0t: %s cycle gave vld=%b writeEn=%b branch=%b",
					$time, what, out.vld, out.writeEn, out.branchTaken);
			end
		end
	endtask

	task automatic finishTest(input string name);
		$display("Test %s finished with %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	initial
	begin : stimulus
		logic [5:0] rOps[9] = '{isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnOr,
			isaPkg::fnNor, isaPkg::fnSlt, isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnMul};
		logic [5:0] iOps[6] = '{isaPkg::opcAddi, isaPkg::opcSlti, isaPkg::opcAndi,
			isaPkg::opcOri, isaPkg::opcLw, isaPkg::opcSw};
		logic [5:0] hlOps[4] = '{isaPkg::fnMult, isaPkg::fnDiv, isaPkg::fnMfhi,
			isaPkg::fnMflo};
		logic [5:0] badOpc[4] = '{isaPkg::opcJ, isaPkg::opcJal, 6'b001111, 6'b111111};
		logic [5:0] badFn[4] = '{isaPkg::fnJr, 6'b000011, 6'b100001, 6'b111111};
		int k;
		isaPkg::instrWord iw;
		logic [W-1:0] a;
		logic [W-1:0] b;
		void'($urandom(32'hf6bc_45ba));
		inVld = 1'b0;
		instr = '0;
		rsVal = '0;
		rtVal = '0;
		modelHi = '0;
		modelLo = '0;

		repeat (4)
		begin
			@(negedge clk);
			checkOut('0, "reset");
		end
		wait (rstN);
		repeat (2)
		begin
			@(posedge clk);
			@(negedge clk);
			checkOut('0, "idle after reset");
		end
		finishTest("reset");

		repeat (300)
		begin
			k = $urandom_range(0, 8);
			runOp(1'b1, randR(rOps[k]), $urandom, $urandom, "R-type");
		end
		finishTest("R-type");

		repeat (300)
		begin
			k = $urandom_range(0, 5);
			runOp(1'b1, randI(iOps[k]), $urandom, $urandom, "I-type");
		end
		finishTest("I-type");

		for (k = 0; k < 40; k++)
		begin
			iw = randI(k[0] ? isaPkg::opcBne : isaPkg::opcBeq);
			a = {{(W-16){iw.iFmt.imm[15]}}, iw.iFmt.imm}; // Equal pair
			if (k[1])
				a = $urandom;
			runOp(1'b1, iw, a, $urandom, "branch");
		end
		finishTest("branch");

		repeat (200)
		begin
			k = $urandom_range(0, 3);
			b = $urandom;
			if ($urandom_range(0, 3) == 0)
				b = '0;
			runOp(1'b1, randR(hlOps[k]), $urandom, b, "HI/LO");
			if ($urandom_range(0, 2) == 0)
			begin
				k = $urandom_range(0, 3);
				runOp(1'b0, randR(hlOps[k]), $urandom, $urandom, "idle"); // Must leave HI/LO alone
			end
		end
		finishTest("HI/LO");

		repeat (40)
		begin
			k = $urandom_range(0, 7);
			iw = (k < 4) ? randI(badOpc[k]) : randR(badFn[k-4]);
			runOp(1'b1, iw, $urandom, $urandom, "no-op");
		end
		finishTest("no-op");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/isaPkg.sv
src/aluPkg.sv
src/aluControl.sv
src/instrDecoder.sv
src/operandSelect.sv
src/execAlu.sv
src/execStage.sv
tests/clockGen.sv
tests/execStage_props.sv
tests/execStageTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module execStageTb -o execSim &&
	./obj_dir/execSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
echo "Simulation passed"
